// ==== core_flit_serializer.sv ====
`timescale 1ns/1ns

// core words in, router flits out
// one header per run of words with the same route
module core_flit_serializer (
	input logic clk,
	input logic reset,
	input logic core_valid,
	input noc_pkg::core_word_t core_data,
	output logic core_ack,
	input logic fifo_full,
	output logic flit_wr,
	output noc_pkg::flit_t flit_data
);

	localparam int slice_w = noc_pkg::slice_w;
	localparam int route_w = noc_pkg::route_w;
	localparam int payload_w = noc_pkg::payload_w;

	noc_pkg::ser_state_t state_q; // current state
	noc_pkg::ser_state_t state_d;

	noc_pkg::route_t header_route_q; // route of the open packet
	noc_pkg::payload_t payload_q; // word being sliced

	noc_pkg::route_t in_route; // route of the word on the core port
	logic same_route; // incoming word can join the open packet
	logic capture; // take the core word into the slice regs

	//////////////////////////////////////////////////
	// input decode
	//////////////////////////////////////////////////

	assign in_route = core_data[noc_pkg::core_word_w-1 -: route_w]; // top 10 bits
	assign same_route = core_valid && (in_route == header_route_q);

	// idle: any valid word, data3: only when the last flit leaves
	assign capture = core_valid &&
		((state_q == noc_pkg::ser_idle) ||
		((state_q == noc_pkg::ser_data3) && !fifo_full));

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb begin
		state_d = state_q; // stall holds by default
		case (state_q)
			noc_pkg::ser_idle: begin
				if (core_valid && !fifo_full)
					state_d = noc_pkg::ser_header;
			end
			noc_pkg::ser_header: begin
				if (!fifo_full)
					state_d = noc_pkg::ser_data1;
			end
			noc_pkg::ser_data1: begin
				if (!fifo_full)
					state_d = noc_pkg::ser_data2;
			end
			noc_pkg::ser_data2: begin
				if (!fifo_full)
					state_d = noc_pkg::ser_data3;
			end
			noc_pkg::ser_data3: begin
				if (!fifo_full) begin
					if (!core_valid)
						state_d = noc_pkg::ser_idle; // packet closed, nothing waiting
					else if (same_route)
						state_d = noc_pkg::ser_data1; // append, no header
					else
						state_d = noc_pkg::ser_header; // new packet
				end
			end
			default: state_d = noc_pkg::ser_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			state_q <= noc_pkg::ser_idle;
		else
			state_q <= state_d;
	end

	// slice registers
	always_ff @(posedge clk) begin
		if (capture) begin
			header_route_q <= in_route;
			payload_q <= core_data[payload_w-1:0]; // code bits above 29 dropped
		end
	end

	//////////////////////////////////////////////////
	// flit output
	//////////////////////////////////////////////////

	assign flit_wr = (state_q != noc_pkg::ser_idle) && !fifo_full;
	assign core_ack = (state_q == noc_pkg::ser_data1) && !fifo_full; // word already latched

	always_comb begin
		case (state_q)
			noc_pkg::ser_header:
				flit_data = {1'b0, header_route_q};
			noc_pkg::ser_data1:
				flit_data = {1'b0, payload_q[payload_w-1 -: slice_w]}; // bits 29:20
			noc_pkg::ser_data2:
				flit_data = {1'b0, payload_q[payload_w-slice_w-1 -: slice_w]}; // bits 19:10
			noc_pkg::ser_data3:
				flit_data = {!same_route, payload_q[slice_w-1:0]}; // tail unless merging
			default:
				flit_data = '0; // idle
		endcase
	end

endmodule

// ==== flit_deserializer.sv ====
`timescale 1ns/1ns

// flits from the link fifo back into route + payload words
module flit_deserializer (
	input logic clk,
	input logic reset,
	input logic fifo_empty,
	input noc_pkg::flit_t fifo_q,
	output logic fifo_rd,
	output logic rx_valid,
	output noc_pkg::route_t rx_route,
	output noc_pkg::payload_t rx_payload,
	input logic rx_ready
);

	localparam int slice_w = noc_pkg::slice_w;
	localparam int payload_w = noc_pkg::payload_w;
	localparam int route_w = noc_pkg::route_w;

	noc_pkg::des_state_t state_q;
	noc_pkg::des_state_t state_d;

	noc_pkg::route_t route_q; // from the last header
	noc_pkg::payload_t payload_q; // shift register, top slice first
	logic tail_q; // tail seen on the last data flit

	logic pop; // flit taken this cycle
	logic in_data; // one of the three data states

	//////////////////////////////////////////////////
	// fifo read side
	//////////////////////////////////////////////////

	assign pop = !fifo_empty && (state_q != noc_pkg::des_hold);
	assign fifo_rd = pop;

	assign in_data = (state_q == noc_pkg::des_data1) ||
		(state_q == noc_pkg::des_data2) ||
		(state_q == noc_pkg::des_data3);

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			noc_pkg::des_header: if (pop) state_d = noc_pkg::des_data1;
			noc_pkg::des_data1: if (pop) state_d = noc_pkg::des_data2;
			noc_pkg::des_data2: if (pop) state_d = noc_pkg::des_data3;
			noc_pkg::des_data3: if (pop) state_d = noc_pkg::des_hold; // word complete
			noc_pkg::des_hold: begin
				if (rx_ready) // handed off
					state_d = tail_q ? noc_pkg::des_header : noc_pkg::des_data1;
			end
			default: state_d = noc_pkg::des_header;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= noc_pkg::des_header; // first flit is a header
			tail_q <= 1'b1;
		end else begin
			state_q <= state_d;
			if (pop && (state_q == noc_pkg::des_data3))
				tail_q <= fifo_q[noc_pkg::tail_bit];
		end
	end

	//////////////////////////////////////////////////
	// route and payload capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pop && (state_q == noc_pkg::des_header))
			route_q <= fifo_q[route_w-1:0]; // header body is the route
		if (pop && in_data)
			payload_q <= {payload_q[payload_w-slice_w-1:0], fifo_q[slice_w-1:0]};
	end

	// rx port, held steady through des_hold
	assign rx_valid = (state_q == noc_pkg::des_hold);
	assign rx_route = route_q;
	assign rx_payload = payload_q;

endmodule

// ==== flit_fifo.sv ====
`timescale 1ns/1ns

// link buffer between serializer and deserializer
// show-ahead read, head flit sits on rd_data
module flit_fifo (
	input logic clk,
	input logic reset,
	input logic wr,
	input noc_pkg::flit_t wr_data,
	output logic full,
	input logic rd,
	output noc_pkg::flit_t rd_data,
	output logic empty
);

	localparam int depth = noc_pkg::fifo_depth;
	localparam int addr_w = $clog2(depth);
	localparam int count_w = $clog2(depth + 1); // holds 0..depth

	noc_pkg::flit_t mem [depth]; // storage, no reset

	logic [addr_w-1:0] wr_ptr; // next slot to write
	logic [addr_w-1:0] rd_ptr; // head slot
	logic [count_w-1:0] count; // occupancy

	logic do_wr; // accepted write
	logic do_rd; // accepted read

	//////////////////////////////////////////////////
	// flags and qualified requests
	//////////////////////////////////////////////////

	assign full = (count == count_w'(depth));
	assign empty = (count == '0);

	assign do_wr = wr && !full; // overflow dropped
	assign do_rd = rd && !empty; // underflow ignored

	assign rd_data = mem[rd_ptr];

	//////////////////////////////////////////////////
	// storage and pointers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or both at once
			endcase
		end
	end

endmodule

// ==== noc_endpoint_assert.sv ====
`timescale 1ns/1ns

// port and link protocol checks
module noc_endpoint_assert (
	input logic clk,
	input logic reset,
	input logic core_valid,
	input logic core_ack,
	input logic flit_wr,
	input logic fifo_full,
	input logic fifo_rd,
	input logic fifo_empty,
	input logic rx_valid,
	input noc_pkg::route_t rx_route,
	input noc_pkg::payload_t rx_payload,
	input logic rx_ready
);

	//////////////////////////////////////////////////
	// core side
	//////////////////////////////////////////////////

	a_ack_with_valid: assert property (@(posedge clk) disable iff (reset)
		core_ack |-> core_valid)
		else $error("core_ack while core_valid low");

	//////////////////////////////////////////////////
	// link fifo
	//////////////////////////////////////////////////

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		flit_wr |-> !fifo_full)
		else $error("flit write into a full fifo");

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		fifo_rd |-> !fifo_empty)
		else $error("flit read from an empty fifo");

	// rx word held until taken
	a_rx_stable: assert property (@(posedge clk) disable iff (reset)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_route) && $stable(rx_payload))
		else $error("rx word dropped or changed while stalled");

	// state regs settle on the first reset edge
	a_quiet_in_reset: assert property (@(posedge clk)
		reset ##1 reset |-> !core_ack && !flit_wr && !rx_valid)
		else $error("outputs active during reset");

endmodule

bind noc_endpoint_top noc_endpoint_assert u_assert (
	.clk (clk),
	.reset (reset),
	.core_valid (core_valid),
	.core_ack (core_ack),
	.flit_wr (flit_wr),
	.fifo_full (fifo_full),
	.fifo_rd (fifo_rd),
	.fifo_empty (fifo_empty),
	.rx_valid (rx_valid),
	.rx_route (rx_route),
	.rx_payload (rx_payload),
	.rx_ready (rx_ready)
);

// ==== noc_endpoint_top.sv ====
`timescale 1ns/1ns

// endpoint transmit and receive path
// serializer -> flit fifo (link stand-in) -> deserializer
module noc_endpoint_top (
	input logic clk,
	input logic reset,
	input logic core_valid,
	input noc_pkg::core_word_t core_data,
	output logic core_ack,
	output logic rx_valid,
	output noc_pkg::route_t rx_route,
	output noc_pkg::payload_t rx_payload,
	input logic rx_ready
);

	//////////////////////////////////////////////////
	// link nets
	//////////////////////////////////////////////////

	logic flit_wr; // serializer write request
	noc_pkg::flit_t flit_data; // flit into the fifo
	logic fifo_full; // back-pressure to the serializer
	logic fifo_rd; // deserializer pop
	noc_pkg::flit_t fifo_q; // head flit
	logic fifo_empty;

	core_flit_serializer u_ser (
		.clk (clk),
		.reset (reset),
		.core_valid (core_valid),
		.core_data (core_data),
		.core_ack (core_ack),
		.fifo_full (fifo_full),
		.flit_wr (flit_wr),
		.flit_data (flit_data)
	);

	flit_fifo u_fifo (
		.clk (clk),
		.reset (reset),
		.wr (flit_wr),
		.wr_data (flit_data),
		.full (fifo_full),
		.rd (fifo_rd),
		.rd_data (fifo_q),
		.empty (fifo_empty)
	);

	flit_deserializer u_des (
		.clk (clk),
		.reset (reset),
		.fifo_empty (fifo_empty),
		.fifo_q (fifo_q),
		.fifo_rd (fifo_rd),
		.rx_valid (rx_valid),
		.rx_route (rx_route),
		.rx_payload (rx_payload),
		.rx_ready (rx_ready) // stalls here fill the fifo
	);

endmodule

// ==== noc_pkg.sv ====
package noc_pkg;

	//////////////////////////////////////////////////
	// core word, msb first
	//
	//	   10      8      24
	//	[ route | code | data ]
	//
	// only the low 30 bits travel over the link,
	// the top two code bits are dropped
	//////////////////////////////////////////////////

	localparam int route_w = 10; // route field
	localparam int code_w = 8; // code field
	localparam int data_w = 24; // core data field
	localparam int core_word_w = route_w + code_w + data_w; // 42
	localparam int payload_w = 30; // routed part of a word

	//////////////////////////////////////////////////
	// flits
	//
	//	header: [ tail | route ]
	//	data:   [ tail | slice ]
	//////////////////////////////////////////////////

	localparam int flit_w = 11; // tail above a 10 bit body
	localparam int tail_bit = flit_w - 1;
	localparam int flits_per_word = 3; // data flits per core word
	localparam int slice_w = payload_w / flits_per_word; // body bits per data flit

	localparam int fifo_depth = 8; // link buffer, power of two

	typedef logic [core_word_w-1:0] core_word_t;
	typedef logic [route_w-1:0] route_t;
	typedef logic [payload_w-1:0] payload_t;
	typedef logic [flit_w-1:0] flit_t;

	// serializer fsm
	typedef enum logic [2:0] {
		ser_idle,
		ser_header, // header flit out
		ser_data1, // top slice, core word acked here
		ser_data2,
		ser_data3 // last slice, tail decided here
	} ser_state_t;

	// deserializer fsm
	typedef enum logic [2:0] {
		des_header, // expecting a header flit
		des_data1,
		des_data2,
		des_data3,
		des_hold // word on the rx port
	} des_state_t;

endpackage

// ==== tb_noc_endpoint.sv ====
`timescale 1ns/1ns

module tb_noc_endpoint;

	localparam int num_words = 200;
	localparam int phase_len = 50; // four stimulus phases
	localparam int reset_cycles = 10;
	localparam int clk_period = 10;
	// 4 flits per word, 4x stall allowance, plus reset
	localparam int timeout_ns = num_words * 4 * clk_period * 4 + reset_cycles * clk_period;
	localparam logic [31:0] lfsr_seed = 32'hec3608f5;
	localparam logic [31:0] lfsr_taps = 32'h80200003; // x^32 + x^22 + x^2 + x + 1
	localparam int tx_src = 0;
	localparam int rx_src = 1;

	logic clk;
	logic reset;
	logic core_valid;
	noc_pkg::core_word_t core_data;
	logic core_ack;
	logic rx_valid;
	noc_pkg::route_t rx_route;
	noc_pkg::payload_t rx_payload;
	logic rx_ready;

	logic [31:0] lfsr_state [2]; // tx and rx streams
	noc_pkg::route_t exp_route_q [$]; // expected words, oldest first
	noc_pkg::payload_t exp_payload_q [$];
	int sent;
	int received;
	bit saw_full; // link fifo filled at least once

	noc_endpoint_top dut (
		.clk (clk),
		.reset (reset),
		.core_valid (core_valid),
		.core_data (core_data),
		.core_ack (core_ack),
		.rx_valid (rx_valid),
		.rx_route (rx_route),
		.rx_payload (rx_payload),
		.rx_ready (rx_ready)
	);

	always #5 clk = ~clk; // 10 ns

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	// galois form, lsb shifted out
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
	endfunction

	// n bits from one stream, one step per bit
	function automatic logic [31:0] rand_bits(input int src, input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr_state[src][0]};
			lfsr_state[src] = lfsr_next(lfsr_state[src]);
		end
		return bits;
	endfunction

	// small pool so runs of one route happen
	function automatic noc_pkg::route_t pick_route(input int idx);
		case (idx % 3)
			0: return 10'h2a5;
			1: return 10'h0f3;
			default: return 10'h31c;
		endcase
	endfunction

	// hold the word until acked, returns 1 ns after the ack edge
	task automatic send_word(input noc_pkg::core_word_t word);
		core_valid = 1'b1;
		core_data = word;
		@(negedge clk);
		while (core_ack !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		#1;
		core_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset && core_ack === 1'b1) begin
			exp_route_q.push_back(core_data[41:32]); // route field
			exp_payload_q.push_back(core_data[29:0]); // low 30 bits travel
		end
		if (!reset && dut.fifo_full === 1'b1)
			saw_full = 1'b1;
	end

	always @(negedge clk) begin : rx_check
		noc_pkg::route_t exp_route;
		noc_pkg::payload_t exp_payload;
		if (!reset && rx_valid === 1'b1 && rx_ready === 1'b1) begin
			assert (exp_route_q.size() != 0)
				else fail_run("a word arrived on the rx port with none outstanding");
			exp_route = exp_route_q.pop_front();
			exp_payload = exp_payload_q.pop_front();
			assert (rx_route === exp_route)
				else fail_run($sformatf("[FAIL] rx_route: got %h, expected %h",
					rx_route, exp_route));
			assert (rx_payload === exp_payload)
				else fail_run($sformatf("[FAIL] rx_payload: got %h, expected %h",
					rx_payload, exp_payload));
			received++;
		end
	end

	//////////////////////////////////////////////////
	// rx_ready, short random stalls, long ones late in the run
	//////////////////////////////////////////////////

	initial begin
		int stall_left;
		stall_left = 0;
		rx_ready = 1'b0;
		@(negedge reset);
		forever begin
			@(posedge clk);
			#1;
			if (stall_left > 0) begin
				rx_ready = 1'b0;
				stall_left--;
			end else if (received >= 3 * phase_len && rx_valid && rand_bits(rx_src, 2) == 0) begin
				stall_left = 16 + rand_bits(rx_src, 4); // long enough to fill the fifo
				rx_ready = 1'b0;
			end else begin
				rx_ready = (rand_bits(rx_src, 2) != 0); // ready 3 of 4
			end
		end
	end

	// watchdog
	initial begin
		#(timeout_ns);
		$display("timeout, only %0d of %0d words came back", received, num_words);
		$display("test failed");
		$fatal(1);
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		noc_pkg::route_t route;
		int gap;
		clk = 1'b0;
		reset = 1'b1;
		core_valid = 1'b0;
		core_data = '0;
		lfsr_state[tx_src] = lfsr_seed;
		lfsr_state[rx_src] = lfsr_seed;
		sent = 0;
		received = 0;
		saw_full = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		assert (core_ack === 1'b0 && rx_valid === 1'b0)
			else fail_run("core_ack or rx_valid high right after reset");
		@(posedge clk);
		#1;
		for (sent = 0; sent < num_words; sent++) begin
			case (sent / phase_len)
				0: begin // single words, idle between
					route = pick_route(rand_bits(tx_src, 2));
					gap = 2 + rand_bits(tx_src, 3);
				end
				1: begin // runs of 10, same route
					route = pick_route(sent / 10);
					gap = 0;
				end
				2: begin // alternate every word
					route = pick_route(sent % 2);
					gap = 0;
				end
				default: begin // random, back to back, under rx stalls
					route = pick_route(rand_bits(tx_src, 2));
					gap = 0;
				end
			endcase
			send_word({route, 8'(rand_bits(tx_src, 8)), 24'(rand_bits(tx_src, 24))});
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		wait (received == num_words);
		@(negedge clk);
		if (exp_route_q.size() == 0 && saw_full) begin
			$display("test passed");
			$finish;
		end else begin
			$display("words left over, or the link fifo never filled");
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

// ==== vlog.f ====
noc_pkg.sv
flit_fifo.sv
core_flit_serializer.sv
flit_deserializer.sv
noc_endpoint_top.sv
noc_endpoint_assert.sv
tb_noc_endpoint.sv
